// ==== include/vz_params.svh ====
`ifndef VZ_PARAMS_SVH
`define VZ_PARAMS_SVH

// Bus widths
`define VZ_ADDR_W 16
`define VZ_DATA_W 8
`define VZ_RAM_AW 14		// 16K system RAM
`define VZ_VRAM_AW 11		// 2K video RAM
// Clocks per CPU cycle
`define VZ_PHASES_NORMAL 14
`define VZ_PHASES_TURBO 4
// Top five address bits of each region
`define VZ_IO_PAGE 5'b01101		// 6800-6FFF
`define VZ_VRAM_PAGE 5'b01110		// 7000-77FF
`define VZ_RAM78_PAGE 5'b01111		// First RAM page
`define VZ_RAM_LAST_PAGE 5'b10110	// RAM ends at B7FF
`define VZ_OPEN_BUS 8'hFF
// PS/2 set 2 make codes
`define VZ_SC_A 8'h1C
`define VZ_SC_B 8'h32
`define VZ_SC_C 8'h21
`define VZ_SC_D 8'h23
`define VZ_SC_E 8'h24
`define VZ_SC_F 8'h2B
`define VZ_SC_G 8'h34
`define VZ_SC_H 8'h33
`define VZ_SC_I 8'h43
`define VZ_SC_J 8'h3B
`define VZ_SC_K 8'h42
`define VZ_SC_L 8'h4B
`define VZ_SC_M 8'h3A
`define VZ_SC_N 8'h31
`define VZ_SC_O 8'h44
`define VZ_SC_P 8'h4D
`define VZ_SC_Q 8'h15
`define VZ_SC_R 8'h2D
`define VZ_SC_S 8'h1B
`define VZ_SC_T 8'h2C
`define VZ_SC_U 8'h3C
`define VZ_SC_V 8'h2A
`define VZ_SC_W 8'h1D
`define VZ_SC_X 8'h22
`define VZ_SC_Y 8'h35
`define VZ_SC_Z 8'h1A
`define VZ_SC_0 8'h45
`define VZ_SC_1 8'h16
`define VZ_SC_2 8'h1E
`define VZ_SC_3 8'h26
`define VZ_SC_4 8'h25
`define VZ_SC_5 8'h2E
`define VZ_SC_6 8'h36
`define VZ_SC_7 8'h3D
`define VZ_SC_8 8'h3E
`define VZ_SC_9 8'h46
`define VZ_SC_SPACE 8'h29
`define VZ_SC_RETURN 8'h5A
`define VZ_SC_CTRL 8'h14
`define VZ_SC_LSHIFT 8'h12
`define VZ_SC_ESC 8'h76
`define VZ_SC_BKSP 8'h66
// Arrows, E0 prefix already stripped
`define VZ_SC_UP 8'h75
`define VZ_SC_LEFT 8'h6B
`define VZ_SC_RIGHT 8'h74
`define VZ_SC_DOWN 8'h72

`endif

// ==== logic/vz_pkg.sv ====
`include "vz_params.svh"

package vz_pkg;

	typedef logic [`VZ_DATA_W-1:0] byte_t;	// CPU data byte
	typedef logic [`VZ_ADDR_W-1:0] addr_t;	// CPU address

	// Where an address lands
	typedef enum logic [1:0]
	{
		REG_OPEN = 2'd0,	// Unmapped, reads FF
		REG_IO   = 2'd1,	// Keyboard in, latch out
		REG_VRAM = 2'd2,
		REG_RAM  = 2'd3
	} region_t;

	// Key matrix, 0 = down, index is row*8 + column
	typedef logic [63:0] key_matrix_t;

	// Extension keys, 0 = down
	// Bits: esc, up, left, right, down, backspace from bit 0
	typedef logic [5:0] key_ex_t;

endpackage

// ==== logic/cpu_phase_gen.sv ====
`timescale 1ns/1ps
`include "vz_params.svh"

module cpu_phase_gen (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic turbo_i,		// Cut the cycle short at phase 3
	output logic cpu_clk_o,
	output logic mem_strobe_o
);

	localparam logic [3:0] PH_LAST_NORMAL = 4'(`VZ_PHASES_NORMAL - 1);
	localparam logic [3:0] PH_LAST_TURBO = 4'(`VZ_PHASES_TURBO - 1);

	logic [3:0] phase_q;	// Position inside the CPU cycle
	logic pulse_q;		// High exactly while phase_q is 1

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			phase_q <= '0;
			pulse_q <= 1'b0;
		end
		else
		begin
			pulse_q <= (phase_q == 4'd0);	// Rises entering phase 1
			if (phase_q == PH_LAST_TURBO && turbo_i)
				phase_q <= '0;		// Turbo wraps after 4 clocks
			else if (phase_q == PH_LAST_NORMAL)
				phase_q <= '0;
			else
				phase_q <= phase_q + 4'd1;
		end
	end

	// CPU clock and memory strobe share the phase 1 pulse
	assign cpu_clk_o = pulse_q;
	assign mem_strobe_o = pulse_q;

	// One-clock strobe, at least 4 clocks apart in any mode
	a_strobe_single: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		mem_strobe_o |=> !mem_strobe_o);

endmodule

// ==== logic/mem_decoder.sv ====
`timescale 1ns/1ps
`include "vz_params.svh"

module mem_decoder (
	input  logic            CLK50MHZ,
	input  logic            RESET_N,
	input  vz_pkg::addr_t   bus_addr_i,
	input  logic            bus_mreq_i,
	input  logic            bus_rd_i,
	input  logic            bus_wr_i,
	input  logic            mem_strobe_i,	// Phase 1 pulse
	input  vz_pkg::byte_t   ram_rdata_i,
	input  vz_pkg::byte_t   vram_rdata_i,
	input  vz_pkg::byte_t   io_rdata_i,	// Latched keyboard byte
	output logic            ram_we_o,
	output logic            vram_we_o,
	output logic            io_we_o,
	output vz_pkg::byte_t   bus_rdata_o
);

	logic [4:0] page;		// 2K page number
	logic wr_cycle;
	vz_pkg::region_t region;
	vz_pkg::region_t region_q;	// Follows the RAM read register

	assign page = bus_addr_i[`VZ_ADDR_W-1:`VZ_ADDR_W-5];

	always_comb
	begin
		if (page == `VZ_IO_PAGE)
			region = vz_pkg::REG_IO;
		else if (page == `VZ_VRAM_PAGE)
			region = vz_pkg::REG_VRAM;
		else if (page >= `VZ_RAM78_PAGE && page <= `VZ_RAM_LAST_PAGE)
			region = vz_pkg::REG_RAM;	// 7800-B7FF in one block
		else
			region = vz_pkg::REG_OPEN;	// ROM space and B800 up
	end

	// Writes land at the edge closing phase 1
	assign wr_cycle = mem_strobe_i & bus_mreq_i & bus_wr_i;
	assign ram_we_o = wr_cycle & (region == vz_pkg::REG_RAM);
	assign vram_we_o = wr_cycle & (region == vz_pkg::REG_VRAM);
	assign io_we_o = wr_cycle & (region == vz_pkg::REG_IO);

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			region_q <= vz_pkg::REG_OPEN;
		else if (bus_mreq_i && bus_rd_i)
			region_q <= region;
		else
			region_q <= vz_pkg::REG_OPEN;	// Idle bus floats high
	end

	always_comb
	begin
		case (region_q)
			vz_pkg::REG_IO:   bus_rdata_o = io_rdata_i;
			vz_pkg::REG_VRAM: bus_rdata_o = vram_rdata_i;
			vz_pkg::REG_RAM:  bus_rdata_o = ram_rdata_i;
			default:          bus_rdata_o = `VZ_OPEN_BUS;
		endcase
	end

	// Regions never overlap, so only one target takes a write
	a_one_we: assert property (@(posedge CLK50MHZ) disable iff (!RESET_N)
		$onehot0({ram_we_o, vram_we_o, io_we_o}));

endmodule

// ==== logic/byte_ram.sv ====
`timescale 1ns/1ps
`include "vz_params.svh"

module byte_ram #(
	parameter int ADDR_W = `VZ_RAM_AW	// 14 for system RAM, 11 for video
) (
	input  logic            CLK50MHZ,
	input  vz_pkg::addr_t   addr_i,		// Full CPU address
	input  vz_pkg::byte_t   wdata_i,
	input  logic            we_i,
	output vz_pkg::byte_t   rdata_o
);

	vz_pkg::byte_t mem [0:(1 << ADDR_W)-1];
	logic [ADDR_W-1:0] word_addr;

	// Upper bits fold away, 7800 hits offset 3800
	assign word_addr = addr_i[ADDR_W-1:0];

	always_ff @(posedge CLK50MHZ)
	begin
		if (we_i)
			mem[word_addr] <= wdata_i;
		rdata_o <= mem[word_addr];	// Old data on a write clock
	end

	// Decoder must hand over a clean address whenever it writes
	a_wr_addr_known: assert property (@(posedge CLK50MHZ)
		we_i |-> !$isunknown(addr_i));

endmodule

// ==== logic/kbd_matrix.sv ====
`timescale 1ns/1ps
`include "vz_params.svh"

module kbd_matrix (
	input  logic            CLK50MHZ,
	input  logic            RESET_N,
	input  logic            key_strobe_i,	// One clock per PS/2 event
	input  logic            key_pressed_i,	// 1 make, 0 break
	input  vz_pkg::byte_t   key_code_i,
	input  vz_pkg::byte_t   scan_row_i,	// Address low byte, 0 selects a row
	input  logic            cass_in_i,
	output vz_pkg::byte_t   key_byte_o
);

	// Extension key bit positions
	localparam int EX_ESC = 0;
	localparam int EX_UP = 1;
	localparam int EX_LEFT = 2;
	localparam int EX_RIGHT = 3;
	localparam int EX_DOWN = 4;
	localparam int EX_BKSP = 5;

	vz_pkg::key_matrix_t key_q;	// Physical keys
	vz_pkg::key_ex_t key_ex_q;
	vz_pkg::key_matrix_t key_eff;	// Keys as the CPU sees them
	logic key_level;		// Level to store, 0 = down

	assign key_level = ~key_pressed_i;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_q <= '1;		// All released
			key_ex_q <= '1;
		end
		else if (key_strobe_i)
		begin
			case (key_code_i)
				// Row 0
				`VZ_SC_T:      key_q[0] <= key_level;
				`VZ_SC_W:      key_q[1] <= key_level;
				`VZ_SC_E:      key_q[3] <= key_level;
				`VZ_SC_Q:      key_q[4] <= key_level;
				`VZ_SC_R:      key_q[5] <= key_level;
				// Row 1
				`VZ_SC_G:      key_q[8] <= key_level;
				`VZ_SC_S:      key_q[9] <= key_level;
				`VZ_SC_CTRL:   key_q[10] <= key_level;
				`VZ_SC_D:      key_q[11] <= key_level;
				`VZ_SC_A:      key_q[12] <= key_level;
				`VZ_SC_F:      key_q[13] <= key_level;
				// Row 2
				`VZ_SC_B:      key_q[16] <= key_level;
				`VZ_SC_X:      key_q[17] <= key_level;
				`VZ_SC_LSHIFT: key_q[18] <= key_level;
				`VZ_SC_C:      key_q[19] <= key_level;
				`VZ_SC_Z:      key_q[20] <= key_level;
				`VZ_SC_V:      key_q[21] <= key_level;
				// Row 3, digits 1-5
				`VZ_SC_5:      key_q[24] <= key_level;
				`VZ_SC_2:      key_q[25] <= key_level;
				`VZ_SC_3:      key_q[27] <= key_level;
				`VZ_SC_1:      key_q[28] <= key_level;
				`VZ_SC_4:      key_q[29] <= key_level;
				// Row 4
				`VZ_SC_N:      key_q[32] <= key_level;
				`VZ_SC_SPACE:  key_q[36] <= key_level;
				`VZ_SC_M:      key_q[37] <= key_level;
				// Row 5, digits 6-0
				`VZ_SC_6:      key_q[40] <= key_level;
				`VZ_SC_9:      key_q[41] <= key_level;
				`VZ_SC_8:      key_q[43] <= key_level;
				`VZ_SC_0:      key_q[44] <= key_level;
				`VZ_SC_7:      key_q[45] <= key_level;
				// Row 6
				`VZ_SC_Y:      key_q[48] <= key_level;
				`VZ_SC_O:      key_q[49] <= key_level;
				`VZ_SC_RETURN: key_q[50] <= key_level;
				`VZ_SC_I:      key_q[51] <= key_level;
				`VZ_SC_P:      key_q[52] <= key_level;
				`VZ_SC_U:      key_q[53] <= key_level;
				// Row 7
				`VZ_SC_H:      key_q[56] <= key_level;
				`VZ_SC_L:      key_q[57] <= key_level;
				`VZ_SC_K:      key_q[59] <= key_level;
				`VZ_SC_J:      key_q[61] <= key_level;
				// Keys with no matrix position of their own
				`VZ_SC_ESC:    key_ex_q[EX_ESC] <= key_level;
				`VZ_SC_UP:     key_ex_q[EX_UP] <= key_level;
				`VZ_SC_LEFT:   key_ex_q[EX_LEFT] <= key_level;
				`VZ_SC_RIGHT:  key_ex_q[EX_RIGHT] <= key_level;
				`VZ_SC_DOWN:   key_ex_q[EX_DOWN] <= key_level;
				`VZ_SC_BKSP:   key_ex_q[EX_BKSP] <= key_level;
				default: ;	// Unmapped codes ignored
			endcase
		end
	end

	// Extension keys become ctrl plus a base key
	always_comb
	begin
		key_eff = key_q;
		key_eff[33] = key_q[33] & key_ex_q[EX_UP];	// Ctrl '.'
		key_eff[35] = key_q[35] & key_ex_q[EX_RIGHT];	// Ctrl ','
		key_eff[36] = key_q[36] & key_ex_q[EX_DOWN];	// Ctrl space
		key_eff[37] = key_q[37] & key_ex_q[EX_LEFT] & key_ex_q[EX_BKSP];
		key_eff[42] = key_q[42] & key_ex_q[EX_ESC];	// Ctrl '-'
		key_eff[10] = key_q[10] & (&key_ex_q);		// Ctrl, row 1 col 2
	end

	// Columns of all selected rows are wired-AND onto the data bus
	always_comb
	begin
		key_byte_o = '1;		// Bit 7 reads high
		key_byte_o[6] = ~cass_in_i;	// Tape input, inverted
		for (int c = 0; c < 6; c++)
		begin
			for (int r = 0; r < 8; r++)
			begin
				if (!scan_row_i[r] && !key_eff[r*8 + c])
					key_byte_o[c] = 1'b0;
			end
		end
	end

endmodule

// ==== logic/io_latch_regs.sv ====
`timescale 1ns/1ps

module io_latch_regs (
	input  logic            CLK50MHZ,
	input  logic            RESET_N,
	input  logic            mem_strobe_i,	// Phase 1 pulse
	input  logic            io_we_i,
	input  vz_pkg::byte_t   bus_wdata_i,
	input  vz_pkg::byte_t   key_byte_i,
	output vz_pkg::byte_t   io_rdata_o,
	output logic [1:0]      aud_o,
	output logic            cass_out_o,
	output logic            vdg_ag_o,
	output logic            vdg_css_o
);

	vz_pkg::byte_t out_latch_q;	// Write-only latch at 6800
	vz_pkg::byte_t key_latch_q;	// Keyboard byte held for the read

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			out_latch_q <= '0;
			key_latch_q <= '0;
		end
		else
		begin
			if (io_we_i)
				out_latch_q <= bus_wdata_i;
			if (mem_strobe_i)
				key_latch_q <= key_byte_i;	// Sampled with the row address
		end
	end

	assign io_rdata_o = key_latch_q;
	assign aud_o = {out_latch_q[0], out_latch_q[5]};	// Speaker pair
	assign cass_out_o = out_latch_q[2];
	assign vdg_ag_o = out_latch_q[3];	// Graphics mode
	assign vdg_css_o = out_latch_q[4];	// Colour set

endmodule

// ==== logic/vz_top.sv ====
`timescale 1ns/1ps
`include "vz_params.svh"

module vz_top (
	input  logic            CLK50MHZ,
	input  logic            RESET_N,
	// CPU bus
	input  vz_pkg::addr_t   bus_addr_i,
	input  vz_pkg::byte_t   bus_wdata_i,
	input  logic            bus_mreq_i,
	input  logic            bus_rd_i,
	input  logic            bus_wr_i,
	input  logic            turbo_i,
	output logic            cpu_clk_o,
	output vz_pkg::byte_t   bus_rdata_o,
	// Keyboard and tape in
	input  logic            key_strobe_i,
	input  logic            key_pressed_i,
	input  vz_pkg::byte_t   key_code_i,
	input  logic            cass_in_i,
	// Output latch bits
	output logic [1:0]      aud_o,
	output logic            cass_out_o,
	output logic            vdg_ag_o,
	output logic            vdg_css_o
);

	logic mem_strobe;
	logic ram_we;
	logic vram_we;
	logic io_we;
	vz_pkg::byte_t ram_rdata;
	vz_pkg::byte_t vram_rdata;
	vz_pkg::byte_t io_rdata;
	vz_pkg::byte_t key_byte;	// Live row-scan result

	cpu_phase_gen u_phase (.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N), .turbo_i(turbo_i),
		.cpu_clk_o(cpu_clk_o), .mem_strobe_o(mem_strobe));

	mem_decoder u_decoder (.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N),
		.bus_addr_i(bus_addr_i), .bus_mreq_i(bus_mreq_i), .bus_rd_i(bus_rd_i),
		.bus_wr_i(bus_wr_i), .mem_strobe_i(mem_strobe), .ram_rdata_i(ram_rdata),
		.vram_rdata_i(vram_rdata), .io_rdata_i(io_rdata), .ram_we_o(ram_we),
		.vram_we_o(vram_we), .io_we_o(io_we), .bus_rdata_o(bus_rdata_o));

	// 7800-B7FF
	byte_ram #(.ADDR_W(`VZ_RAM_AW)) system_ram (.CLK50MHZ(CLK50MHZ), .addr_i(bus_addr_i),
		.wdata_i(bus_wdata_i), .we_i(ram_we), .rdata_o(ram_rdata));

	// 7000-77FF
	byte_ram #(.ADDR_W(`VZ_VRAM_AW)) video_ram (.CLK50MHZ(CLK50MHZ), .addr_i(bus_addr_i),
		.wdata_i(bus_wdata_i), .we_i(vram_we), .rdata_o(vram_rdata));

	kbd_matrix u_kbd (.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N), .key_strobe_i(key_strobe_i),
		.key_pressed_i(key_pressed_i), .key_code_i(key_code_i),
		.scan_row_i(bus_addr_i[7:0]), .cass_in_i(cass_in_i), .key_byte_o(key_byte));

	io_latch_regs u_io (.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N), .mem_strobe_i(mem_strobe),
		.io_we_i(io_we), .bus_wdata_i(bus_wdata_i), .key_byte_i(key_byte),
		.io_rdata_o(io_rdata), .aud_o(aud_o), .cass_out_o(cass_out_o),
		.vdg_ag_o(vdg_ag_o), .vdg_css_o(vdg_css_o));

endmodule

// ==== bench/tb_vz_top.sv ====
`timescale 1ns/1ps
`include "vz_params.svh"

module tb_vz_top;

	localparam int N_RAM = 48;		// Random RAM writes
	localparam int N_VRAM = 24;
	localparam int N_OPEN = 16;		// Writes into unmapped space
	localparam int N_KEY = 40;		// Key events, one read each
	localparam int N_LATCH = 12;
	// Two CPU cycles per bus access, summed over the six tests
	localparam int TEST_CYCLES = 12 + 2 * (2 * N_RAM + 7) + 2 * (2 * N_VRAM + N_RAM + 2 * N_OPEN)
		+ 2 * N_KEY + 40 + 60 + 4 * N_LATCH;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * 14 * 20;

	// Scan codes driven in the random key test, with their matrix index
	localparam logic [7:0] KEY_CODE [16] = '{`VZ_SC_T, `VZ_SC_Q, `VZ_SC_CTRL, `VZ_SC_A,
		`VZ_SC_LSHIFT, `VZ_SC_Z, `VZ_SC_5, `VZ_SC_1, `VZ_SC_SPACE, `VZ_SC_M, `VZ_SC_6,
		`VZ_SC_0, `VZ_SC_RETURN, `VZ_SC_P, `VZ_SC_H, `VZ_SC_J};
	localparam int KEY_POS [16] = '{0, 4, 10, 12, 18, 20, 24, 28, 36, 37, 40, 44, 50, 52, 56, 61};
	// Extension keys and the base key each one stands for
	localparam logic [7:0] EX_CODE [6] = '{`VZ_SC_ESC, `VZ_SC_UP, `VZ_SC_LEFT, `VZ_SC_RIGHT,
		`VZ_SC_DOWN, `VZ_SC_BKSP};
	localparam int EX_BASE [6] = '{42, 33, 37, 35, 36, 37};
	localparam logic [7:0] EX_ROWS [4] = '{8'h00, 8'hFD, 8'hEF, 8'hDF};	// All, row 1, 4, 5

	logic CLK50MHZ;
	logic RESET_N;
	vz_pkg::addr_t bus_addr;
	vz_pkg::byte_t bus_wdata;
	logic bus_mreq;
	logic bus_rd;
	logic bus_wr;
	logic turbo;
	logic cpu_clk;
	vz_pkg::byte_t bus_rdata;
	logic key_strobe;
	logic key_pressed;
	vz_pkg::byte_t key_code;
	logic cass_in;
	logic [1:0] aud;
	logic cass_out;
	logic vdg_ag;
	logic vdg_css;

	integer seed;
	int errors;
	int checks;
	int test_errors;
	int test_checks;
	int n;			// Clocks between CPU pulses
	int k;
	logic [31:0] r;
	logic [15:0] a;
	logic [7:0] d;
	logic [7:0] row;
	logic [63:0] keys_down;	// Shadow key set, 1 = down
	logic [63:0] ctrl_base;
	logic [7:0] shadow [0:65535];	// RAM and VRAM by CPU address
	logic [15:0] ram_list [$];
	logic [15:0] vram_list [$];
	logic [15:0] open_list [$];

	vz_top dut (.CLK50MHZ(CLK50MHZ), .RESET_N(RESET_N), .bus_addr_i(bus_addr),
		.bus_wdata_i(bus_wdata), .bus_mreq_i(bus_mreq), .bus_rd_i(bus_rd), .bus_wr_i(bus_wr),
		.turbo_i(turbo), .cpu_clk_o(cpu_clk), .bus_rdata_o(bus_rdata),
		.key_strobe_i(key_strobe), .key_pressed_i(key_pressed), .key_code_i(key_code),
		.cass_in_i(cass_in), .aud_o(aud), .cass_out_o(cass_out), .vdg_ag_o(vdg_ag),
		.vdg_css_o(vdg_css));

	always #10 CLK50MHZ = ~CLK50MHZ;	// 50 MHz

	// Expected row-scan byte, selected rows wired-AND per column
	function automatic logic [7:0] kbd_ref(input logic [63:0] down, input logic [7:0] rows,
		input logic cass);
		logic [7:0] b;
		b = 8'hFF;			// Bit 7 stays high
		b[6] = ~cass;
		for (int c = 0; c < 6; c++)
			for (int rr = 0; rr < 8; rr++)
				if (!rows[rr] && down[rr*8 + c])
					b[c] = 1'b0;
		return b;
	endfunction

	task automatic check_equal(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		test_checks++;
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s, got %02h, expected %02h", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic test_done(input string name);
		$display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	// Lands on the falling edge inside the phase 1 pulse
	task automatic wait_pulse;
		@(negedge CLK50MHZ);
		while (cpu_clk !== 1'b1)
			@(negedge CLK50MHZ);
	endtask

	task automatic measure_period(output int clocks);
		wait_pulse();
		clocks = 0;
		do
		begin
			@(negedge CLK50MHZ);
			clocks++;
		end
		while (cpu_clk !== 1'b1);
	endtask

	// One CPU access, driven after a pulse and held through the next one
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data, input logic write,
		output logic [7:0] rdata);
		wait_pulse();
		@(negedge CLK50MHZ);	// Phase 2
		bus_addr = addr;
		bus_wdata = data;
		bus_mreq = 1'b1;
		bus_rd = ~write;
		bus_wr = write;
		wait_pulse();		// Write and key latch at the end of this pulse
		@(negedge CLK50MHZ);
		rdata = bus_rdata;
		bus_mreq = 1'b0;
		bus_rd = 1'b0;
		bus_wr = 1'b0;
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] ignored;
		bus_cycle(addr, data, 1'b1, ignored);
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [7:0] exp, input string what);
		logic [7:0] got;
		bus_cycle(addr, 8'h00, 1'b0, got);
		check_equal(got, exp, $sformatf("%s at %04h", what, addr));
	endtask

	task automatic key_event(input logic [7:0] code, input logic pressed);
		@(negedge CLK50MHZ);
		key_code = code;
		key_pressed = pressed;
		key_strobe = 1'b1;	// Single clock strobe
		@(negedge CLK50MHZ);
		key_strobe = 1'b0;
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		seed = 27;
		errors = 0;
		checks = 0;
		test_errors = 0;
		test_checks = 0;
		keys_down = '0;
		CLK50MHZ = 1'b0;
		RESET_N = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		bus_mreq = 1'b0;
		bus_rd = 1'b0;
		bus_wr = 1'b0;
		turbo = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		cass_in = 1'b0;
		repeat (10) @(negedge CLK50MHZ);
		RESET_N = 1'b1;

		// Latch cleared, pulse spacing in both modes
		check_equal({3'b000, aud, cass_out, vdg_ag, vdg_css}, 8'h00, "latch outputs after reset");
		measure_period(n);
		check_equal(8'(n), 8'd14, "normal cycle length");
		turbo = 1'b1;
		measure_period(n);	// Settle into turbo
		measure_period(n);
		check_equal(8'(n), 8'd4, "turbo cycle length");
		turbo = 1'b0;
		measure_period(n);
		measure_period(n);
		check_equal(8'(n), 8'd14, "normal cycle after turbo");
		test_done("test 1 reset and phase");

		for (int i = 0; i < N_RAM; i++)
		begin
			r = $random(seed);
			a = 16'h7800 + {2'b00, r[13:0]};	// 7800-B7FF
			d = r[23:16];
			mem_write(a, d);
			shadow[a] = d;
			ram_list.push_back(a);
		end
		foreach (ram_list[i])
			read_expect(ram_list[i], shadow[ram_list[i]], "RAM");
		// First RAM page sits at offset 3800, VRAM shares the low bits only
		mem_write(16'h7000, 8'h5A);
		shadow[16'h7000] = 8'h5A;
		mem_write(16'h7800, 8'hA5);
		shadow[16'h7800] = 8'hA5;
		ram_list.push_back(16'h7800);
		read_expect(16'h7800, 8'hA5, "RAM first page");
		read_expect(16'h3800, `VZ_OPEN_BUS, "ROM space");
		read_expect(16'hB800, `VZ_OPEN_BUS, "above RAM");
		read_expect(16'hF800, `VZ_OPEN_BUS, "top page");
		read_expect(16'h7000, 8'h5A, "VRAM offset 0");
		test_done("test 2 system RAM");

		for (int i = 0; i < N_VRAM; i++)
		begin
			r = $random(seed);
			a = {5'b01110, r[10:0]};		// 7000-77FF
			d = r[23:16];
			mem_write(a, d);
			shadow[a] = d;
			vram_list.push_back(a);
		end
		// Unmapped writes share the low bits of stored RAM and VRAM bytes
		for (int i = 0; i < N_OPEN; i++)
		begin
			r = $random(seed);
			if (i % 2 == 0)
			begin
				a = {2'b00, ram_list[i][13:0]};	// ROM space, same RAM offset
				d = ~shadow[ram_list[i]];
			end
			else
			begin
				a = {2'b11, r[2:0], vram_list[i][10:0]};	// C000 up, same VRAM offset
				d = ~shadow[vram_list[i]];
			end
			mem_write(a, d);
			open_list.push_back(a);
		end
		foreach (vram_list[i])
			read_expect(vram_list[i], shadow[vram_list[i]], "VRAM");
		foreach (ram_list[i])
			read_expect(ram_list[i], shadow[ram_list[i]], "RAM kept");
		foreach (open_list[i])
			read_expect(open_list[i], `VZ_OPEN_BUS, "open bus");
		test_done("test 3 VRAM and open bus");

		for (int i = 0; i < N_KEY; i++)
		begin
			r = $random(seed);
			k = int'(r[3:0]);
			key_event(KEY_CODE[k], r[4]);
			keys_down[KEY_POS[k]] = r[4];
			row = r[15:8];			// 0 bits pick rows
			cass_in = r[5];
			read_expect({8'h68, row}, kbd_ref(keys_down, row, r[5]), "keyboard");
		end
		for (int i = 0; i < 16; i++)
			key_event(KEY_CODE[i], 1'b0);
		keys_down = '0;
		cass_in = 1'b0;
		read_expect(16'h6800, kbd_ref(keys_down, 8'h00, 1'b0), "all keys released");
		test_done("test 4 keyboard");

		for (int e = 0; e < 6; e++)
		begin
			key_event(EX_CODE[e], 1'b1);
			ctrl_base = (64'd1 << 10) | (64'd1 << EX_BASE[e]);	// Ctrl plus base
			for (int j = 0; j < 4; j++)
				read_expect({8'h68, EX_ROWS[j]}, kbd_ref(ctrl_base, EX_ROWS[j], 1'b0),
					"extension key");
			key_event(EX_CODE[e], 1'b0);
			read_expect(16'h6800, kbd_ref(64'd0, 8'h00, 1'b0), "extension key released");
		end
		test_done("test 5 extension keys");

		for (int i = 0; i < N_LATCH; i++)
		begin
			r = $random(seed);
			a = {5'b01101, r[10:0]};		// Anywhere in 6800-6FFF
			d = r[23:16];
			mem_write(a, d);
			check_equal({3'b000, aud, cass_out, vdg_ag, vdg_css},
				{3'b000, d[0], d[5], d[2], d[3], d[4]}, "latch outputs");
			a = {4'h8, r[27:16]};			// RAM page 8000-8FFF
			mem_write(a, ~d);
			shadow[a] = ~d;
			check_equal({3'b000, aud, cass_out, vdg_ag, vdg_css},
				{3'b000, d[0], d[5], d[2], d[3], d[4]}, "latch after RAM write");
		end
		test_done("test 6 output latch");

		$display("All tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
logic/vz_pkg.sv
logic/cpu_phase_gen.sv
logic/mem_decoder.sv
logic/byte_ram.sv
logic/kbd_matrix.sv
logic/io_latch_regs.sv
logic/vz_top.sv
bench/tb_vz_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the VZ bus testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_vz_top -o sim_vz
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_vz > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0
